//--- cpu_pkg.sv
package cpu_pkg;

  //////////////////////////////////////////////////
  // widths
  //////////////////////////////////////////////////
  localparam int XLEN     = 32;
  localparam int REG_AW   = 5;
  localparam int LINK_REG = 31;

  //////////////////////////////////////////////////
  // opcodes, bits 31:26
  //////////////////////////////////////////////////
  localparam logic [5:0] OP_RTYPE = 6'h00;
  localparam logic [5:0] OP_J     = 6'h02;
  localparam logic [5:0] OP_JAL   = 6'h03;
  localparam logic [5:0] OP_BEQZ  = 6'h04;
  localparam logic [5:0] OP_BNEZ  = 6'h05;
  localparam logic [5:0] OP_ADDI  = 6'h08;
  localparam logic [5:0] OP_ANDI  = 6'h0c;
  localparam logic [5:0] OP_ORI   = 6'h0d;
  localparam logic [5:0] OP_XORI  = 6'h0e;
  localparam logic [5:0] OP_LHI   = 6'h0f;
  localparam logic [5:0] OP_JR    = 6'h12;
  localparam logic [5:0] OP_LW    = 6'h23;
  localparam logic [5:0] OP_SW    = 6'h2b;

  // r-type function codes, bits 5:0
  localparam logic [5:0] FN_SLL = 6'h04;
  localparam logic [5:0] FN_SRL = 6'h06;
  localparam logic [5:0] FN_SRA = 6'h07;
  localparam logic [5:0] FN_ADD = 6'h20;
  localparam logic [5:0] FN_SUB = 6'h22;
  localparam logic [5:0] FN_AND = 6'h24;
  localparam logic [5:0] FN_OR  = 6'h25;
  localparam logic [5:0] FN_XOR = 6'h26;
  localparam logic [5:0] FN_SLT = 6'h2a;

  // execute-stage operation
  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT,
    ALU_LHI, ALU_LINK
  } alu_op_t;

  // where an execute operand comes from
  typedef enum logic [1:0] {
    FWD_REG,
    FWD_MEM,
    FWD_WB
  } fwd_sel_t;

endpackage

//--- reg_file.sv
`timescale 1ns/1ps

module reg_file (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [cpu_pkg::REG_AW-1:0] rs1,
  input  logic [cpu_pkg::REG_AW-1:0] rs2,
  input  logic                       wr_en,
  input  logic [cpu_pkg::REG_AW-1:0] wr_addr,
  input  logic [cpu_pkg::XLEN-1:0]   wr_data,
  output logic [cpu_pkg::XLEN-1:0]   rd1,
  output logic [cpu_pkg::XLEN-1:0]   rd2
);
  import cpu_pkg::*;

  logic [XLEN-1:0] regs [32];
  logic            wr_live;

  // writes to r0 are dropped here
  assign wr_live = wr_en && (wr_addr != '0);

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 32; i++) begin
        regs[i] <= '0;
      end
    end else if (wr_live) begin
      regs[wr_addr] <= wr_data;
    end
  end

  // r0 reads zero, same-cycle write passes straight through
  assign rd1 = (rs1 == '0) ? '0 : (wr_live && wr_addr == rs1) ? wr_data : regs[rs1];
  assign rd2 = (rs2 == '0) ? '0 : (wr_live && wr_addr == rs2) ? wr_data : regs[rs2];

endmodule

//--- fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit (
  input  logic                     clk,
  input  logic                     rst,
  input  logic                     stall,
  input  logic                     id_valid,
  input  logic [cpu_pkg::XLEN-1:0] id_pc,
  input  logic [15:0]              id_imm16,
  input  logic [25:0]              id_imm26,
  input  logic [cpu_pkg::XLEN-1:0] rs1_value,
  input  logic                     branch_z,
  input  logic                     branch_nz,
  input  logic                     jmp,
  input  logic                     jmp_reg,
  output logic [cpu_pkg::XLEN-1:0] pc
);
  import cpu_pkg::*;

  logic [XLEN-1:0] seq_pc;
  logic [XLEN-1:0] br_target;
  logic [XLEN-1:0] jmp_target;
  logic [XLEN-1:0] next_pc;
  logic            rs1_zero;
  logic            take_branch;

  // targets are relative to the pc after the branch itself
  assign seq_pc     = pc + XLEN'(4);
  assign br_target  = id_pc + XLEN'(4) + {{(XLEN-16){id_imm16[15]}}, id_imm16};
  assign jmp_target = id_pc + XLEN'(4) + {{(XLEN-26){id_imm26[25]}}, id_imm26};

  // zero test for beqz / bnez
  assign rs1_zero    = (rs1_value == '0);
  assign take_branch = (branch_z & rs1_zero) | (branch_nz & ~rs1_zero);

  // the slot after the decode-stage branch is already being fetched,
  // so redirecting here gives the one delay slot
  always_comb begin
    if (id_valid && take_branch) begin
      next_pc = br_target;
    end else if (id_valid && jmp) begin
      next_pc = jmp_target;
    end else if (id_valid && jmp_reg) begin
      next_pc = rs1_value;
    end else begin
      next_pc = seq_pc;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      pc <= '0;
    end else if (!stall) begin
      pc <= next_pc;
    end
  end

endmodule

//--- decode_ctrl.sv
`timescale 1ns/1ps

module decode_ctrl (
  input  logic                       [cpu_pkg::XLEN-1:0]   instr,
  output logic                                             reg_wr,
  output logic                       [cpu_pkg::REG_AW-1:0] dest,
  output cpu_pkg::alu_op_t                                 alu_op,
  output logic                                             alu_src_imm,
  output logic                                             imm_zero_ext,
  output logic                                             mem_rd,
  output logic                                             mem_wr,
  output logic                                             branch_z,
  output logic                                             branch_nz,
  output logic                                             jmp,
  output logic                                             jmp_reg,
  output logic                                             uses_rs1,
  output logic                                             uses_rs2
);
  import cpu_pkg::*;

  logic [5:0]        opcode;
  logic [5:0]        func;
  logic [REG_AW-1:0] f_rs2;
  logic [REG_AW-1:0] f_rd;

  assign opcode = instr[31:26];
  assign func   = instr[5:0];
  assign f_rs2  = instr[20:16];
  assign f_rd   = instr[15:11];

  always_comb begin
    // anything not matched below is a no-op
    reg_wr       = 1'b0;
    dest         = '0;
    alu_op       = ALU_ADD;
    alu_src_imm  = 1'b0;
    imm_zero_ext = 1'b0;
    mem_rd       = 1'b0;
    mem_wr       = 1'b0;
    branch_z     = 1'b0;
    branch_nz    = 1'b0;
    jmp          = 1'b0;
    jmp_reg      = 1'b0;
    uses_rs1     = 1'b0;
    uses_rs2     = 1'b0;

    case (opcode)
      OP_RTYPE: begin
        reg_wr   = 1'b1;
        uses_rs1 = 1'b1;
        uses_rs2 = 1'b1;
        dest     = f_rd;
        case (func)
          FN_ADD:  alu_op = ALU_ADD;
          FN_SUB:  alu_op = ALU_SUB;
          FN_AND:  alu_op = ALU_AND;
          FN_OR:   alu_op = ALU_OR;
          FN_XOR:  alu_op = ALU_XOR;
          FN_SLL:  alu_op = ALU_SLL;
          FN_SRL:  alu_op = ALU_SRL;
          FN_SRA:  alu_op = ALU_SRA;
          FN_SLT:  alu_op = ALU_SLT;
          default: begin
            // unknown function, drop everything again
            reg_wr   = 1'b0;
            uses_rs1 = 1'b0;
            uses_rs2 = 1'b0;
            dest     = '0;
          end
        endcase
      end
      OP_ADDI, OP_ANDI, OP_ORI, OP_XORI: begin
        reg_wr       = 1'b1;
        uses_rs1     = 1'b1;
        alu_src_imm  = 1'b1;
        dest         = f_rs2;
        // logical immediates are zero extended
        imm_zero_ext = (opcode != OP_ADDI);
        case (opcode)
          OP_ANDI: alu_op = ALU_AND;
          OP_ORI:  alu_op = ALU_OR;
          OP_XORI: alu_op = ALU_XOR;
          default: alu_op = ALU_ADD;
        endcase
      end
      OP_LHI: begin
        reg_wr = 1'b1;
        dest   = f_rs2;
        alu_op = ALU_LHI;
      end
      OP_LW: begin
        reg_wr      = 1'b1;
        mem_rd      = 1'b1;
        uses_rs1    = 1'b1;
        alu_src_imm = 1'b1;
        dest        = f_rs2;
      end
      OP_SW: begin
        // rs2 carries the store data
        mem_wr      = 1'b1;
        uses_rs1    = 1'b1;
        uses_rs2    = 1'b1;
        alu_src_imm = 1'b1;
      end
      OP_BEQZ: begin
        branch_z = 1'b1;
        uses_rs1 = 1'b1;
      end
      OP_BNEZ: begin
        branch_nz = 1'b1;
        uses_rs1  = 1'b1;
      end
      OP_J: jmp = 1'b1;
      OP_JAL: begin
        jmp    = 1'b1;
        reg_wr = 1'b1;
        alu_op = ALU_LINK;
        dest   = REG_AW'(LINK_REG);
      end
      OP_JR: begin
        jmp_reg  = 1'b1;
        uses_rs1 = 1'b1;
      end
      default: ;
    endcase
  end

endmodule

//--- hazard_unit.sv
`timescale 1ns/1ps

module hazard_unit (
  input  logic [cpu_pkg::REG_AW-1:0] id_rs1,
  input  logic [cpu_pkg::REG_AW-1:0] id_rs2,
  input  logic                       id_uses_rs1,
  input  logic                       id_uses_rs2,
  input  logic                       id_ctrl_flow,
  input  logic                       ex_valid,
  input  logic                       ex_reg_wr,
  input  logic                       ex_mem_rd,
  input  logic [cpu_pkg::REG_AW-1:0] ex_dest,
  input  logic [cpu_pkg::REG_AW-1:0] ex_rs1,
  input  logic [cpu_pkg::REG_AW-1:0] ex_rs2,
  input  logic                       mem_valid,
  input  logic                       mem_reg_wr,
  input  logic [cpu_pkg::REG_AW-1:0] mem_dest,
  input  logic                       wb_valid,
  input  logic                       wb_reg_wr,
  input  logic [cpu_pkg::REG_AW-1:0] wb_dest,
  output logic                       stall,
  output cpu_pkg::fwd_sel_t          fwd_a,
  output cpu_pkg::fwd_sel_t          fwd_b
);
  import cpu_pkg::*;

  logic ex_live, mem_live, wb_live;
  logic ex_hit, mem_hit;
  logic load_use, ctrl_wait;

  // a stage only counts if it really writes a nonzero register
  assign ex_live  = ex_valid  & ex_reg_wr  & (ex_dest  != '0);
  assign mem_live = mem_valid & mem_reg_wr & (mem_dest != '0);
  assign wb_live  = wb_valid  & wb_reg_wr  & (wb_dest  != '0);

  // decode sources against execute and memory destinations
  assign ex_hit  = ex_live & ((id_uses_rs1 & (ex_dest == id_rs1)) |
                              (id_uses_rs2 & (ex_dest == id_rs2)));
  assign mem_hit = mem_live & ((id_uses_rs1 & (mem_dest == id_rs1)) |
                               (id_uses_rs2 & (mem_dest == id_rs2)));

  // load data only shows up in write-back
  assign load_use = ex_hit & ex_mem_rd;
  // branches resolve in decode, write-back reaches them through the reg file
  assign ctrl_wait = id_ctrl_flow & (ex_hit | mem_hit);
  assign stall     = load_use | ctrl_wait;

  // younger producer wins
  assign fwd_a = (mem_live && mem_dest == ex_rs1) ? FWD_MEM :
                 (wb_live  && wb_dest  == ex_rs1) ? FWD_WB  : FWD_REG;
  assign fwd_b = (mem_live && mem_dest == ex_rs2) ? FWD_MEM :
                 (wb_live  && wb_dest  == ex_rs2) ? FWD_WB  : FWD_REG;

endmodule

//--- alu_exec.sv
`timescale 1ns/1ps

module alu_exec (
  input  cpu_pkg::fwd_sel_t          fwd_a,
  input  cpu_pkg::fwd_sel_t          fwd_b,
  input  logic [cpu_pkg::XLEN-1:0]   reg_a,
  input  logic [cpu_pkg::XLEN-1:0]   reg_b,
  input  logic [cpu_pkg::XLEN-1:0]   mem_result,
  input  logic [cpu_pkg::XLEN-1:0]   wb_result,
  input  logic [15:0]                imm16,
  input  logic [cpu_pkg::XLEN-1:0]   pc,
  input  cpu_pkg::alu_op_t           alu_op,
  input  logic                       alu_src_imm,
  input  logic                       imm_zero_ext,
  output logic [cpu_pkg::XLEN-1:0]   result,
  output logic [cpu_pkg::XLEN-1:0]   store_data
);
  import cpu_pkg::*;

  logic [XLEN-1:0] op_a;
  logic [XLEN-1:0] op_b_reg;
  logic [XLEN-1:0] op_b;
  logic [XLEN-1:0] imm_ext;
  logic [4:0]      shamt;

  function automatic logic [XLEN-1:0] pick_src(input fwd_sel_t sel,
                                               input logic [XLEN-1:0] from_reg,
                                               input logic [XLEN-1:0] from_mem,
                                               input logic [XLEN-1:0] from_wb);
    case (sel)
      FWD_MEM: return from_mem;
      FWD_WB:  return from_wb;
      default: return from_reg;
    endcase
  endfunction

  // operand forwarding
  assign op_a     = pick_src(fwd_a, reg_a, mem_result, wb_result);
  assign op_b_reg = pick_src(fwd_b, reg_b, mem_result, wb_result);

  // sw data is the forwarded rs2, not the immediate
  assign store_data = op_b_reg;

  assign imm_ext = imm_zero_ext ? {{(XLEN-16){1'b0}}, imm16} :
                                  {{(XLEN-16){imm16[15]}}, imm16};
  assign op_b    = alu_src_imm ? imm_ext : op_b_reg;
  assign shamt   = op_b[4:0];

  // loads and stores come through ALU_ADD as address
  always_comb begin
    case (alu_op)
      ALU_SUB:  result = op_a - op_b;
      ALU_AND:  result = op_a & op_b;
      ALU_OR:   result = op_a | op_b;
      ALU_XOR:  result = op_a ^ op_b;
      ALU_SLL:  result = op_a << shamt;
      ALU_SRL:  result = op_a >> shamt;
      ALU_SRA:  result = $signed(op_a) >>> shamt;
      ALU_SLT:  result = {{(XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
      ALU_LHI:  result = {imm16, {(XLEN-16){1'b0}}};
      // return address skips the delay slot
      ALU_LINK: result = pc + XLEN'(8);
      default:  result = op_a + op_b;
    endcase
  end

endmodule

//--- pipeline.sv
`timescale 1ns/1ps

module pipeline (
  input  logic                     clk,
  input  logic                     rst,
  input  logic [cpu_pkg::XLEN-1:0] instruction,
  input  logic [cpu_pkg::XLEN-1:0] mem_read_data,
  output logic [cpu_pkg::XLEN-1:0] pc,
  output logic [cpu_pkg::XLEN-1:0] mem_addr,
  output logic [cpu_pkg::XLEN-1:0] mem_write_data,
  output logic                     mem_wr
);
  import cpu_pkg::*;

  //////////////////////////////////////////////////
  // stage registers
  //////////////////////////////////////////////////
  typedef struct packed {
    logic            valid;
    logic [XLEN-1:0] pc;
    logic [XLEN-1:0] instr;
  } if_id_t;

  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   pc;
    logic [REG_AW-1:0] rs1;
    logic [REG_AW-1:0] rs2;
    logic [XLEN-1:0]   rs1_val;
    logic [XLEN-1:0]   rs2_val;
    logic [15:0]       imm16;
    logic [REG_AW-1:0] dest;
    logic              reg_wr;
    logic              mem_rd;
    logic              mem_wr;
    alu_op_t           alu_op;
    logic              alu_src_imm;
    logic              imm_zero_ext;
  } id_ex_t;

  typedef struct packed {
    logic              valid;
    logic [REG_AW-1:0] dest;
    logic              reg_wr;
    logic              mem_rd;
    logic              mem_wr;
    logic [XLEN-1:0]   result;
    logic [XLEN-1:0]   store_data;
  } ex_mem_t;

  typedef struct packed {
    logic              valid;
    logic [REG_AW-1:0] dest;
    logic              reg_wr;
    logic              mem_rd;
    logic [XLEN-1:0]   result;
    logic [XLEN-1:0]   read_data;
  } mem_wb_t;

  if_id_t  if_id;
  id_ex_t  id_ex;
  ex_mem_t ex_mem;
  mem_wb_t mem_wb;

  // decode fields
  logic [REG_AW-1:0] id_rs1, id_rs2;
  logic [XLEN-1:0]   rf_rd1, rf_rd2;
  logic              dec_reg_wr, dec_alu_src_imm, dec_imm_zero_ext;
  logic              dec_mem_rd, dec_mem_wr;
  logic              dec_branch_z, dec_branch_nz, dec_jmp, dec_jmp_reg;
  logic              dec_uses_rs1, dec_uses_rs2;
  logic [REG_AW-1:0] dec_dest;
  alu_op_t           dec_alu_op;

  // hazards, execute, write-back
  logic              stall;
  logic              id_ctrl_flow;
  fwd_sel_t          fwd_a, fwd_b;
  logic [XLEN-1:0]   ex_result, ex_store_data;
  logic [XLEN-1:0]   wb_data;

  assign id_rs1 = if_id.instr[25:21];
  assign id_rs2 = if_id.instr[20:16];
  // only instructions that wait on a register in decode
  assign id_ctrl_flow = dec_branch_z | dec_branch_nz | dec_jmp_reg;

  fetch_unit u_fetch (
    .clk(clk), .rst(rst), .stall(stall),
    .id_valid(if_id.valid), .id_pc(if_id.pc),
    .id_imm16(if_id.instr[15:0]), .id_imm26(if_id.instr[25:0]),
    .rs1_value(rf_rd1),
    .branch_z(dec_branch_z), .branch_nz(dec_branch_nz),
    .jmp(dec_jmp), .jmp_reg(dec_jmp_reg),
    .pc(pc)
  );

  reg_file u_regs (
    .clk(clk), .rst(rst),
    .rs1(id_rs1), .rs2(id_rs2),
    .wr_en(mem_wb.valid & mem_wb.reg_wr),
    .wr_addr(mem_wb.dest), .wr_data(wb_data),
    .rd1(rf_rd1), .rd2(rf_rd2)
  );

  decode_ctrl u_dec (
    .instr(if_id.instr),
    .reg_wr(dec_reg_wr), .dest(dec_dest), .alu_op(dec_alu_op),
    .alu_src_imm(dec_alu_src_imm), .imm_zero_ext(dec_imm_zero_ext),
    .mem_rd(dec_mem_rd), .mem_wr(dec_mem_wr),
    .branch_z(dec_branch_z), .branch_nz(dec_branch_nz),
    .jmp(dec_jmp), .jmp_reg(dec_jmp_reg),
    .uses_rs1(dec_uses_rs1), .uses_rs2(dec_uses_rs2)
  );

  // decode-side inputs masked by the if/id valid bit
  hazard_unit u_haz (
    .id_rs1(id_rs1), .id_rs2(id_rs2),
    .id_uses_rs1(if_id.valid & dec_uses_rs1),
    .id_uses_rs2(if_id.valid & dec_uses_rs2),
    .id_ctrl_flow(if_id.valid & id_ctrl_flow),
    .ex_valid(id_ex.valid), .ex_reg_wr(id_ex.reg_wr), .ex_mem_rd(id_ex.mem_rd),
    .ex_dest(id_ex.dest), .ex_rs1(id_ex.rs1), .ex_rs2(id_ex.rs2),
    .mem_valid(ex_mem.valid), .mem_reg_wr(ex_mem.reg_wr), .mem_dest(ex_mem.dest),
    .wb_valid(mem_wb.valid), .wb_reg_wr(mem_wb.reg_wr), .wb_dest(mem_wb.dest),
    .stall(stall), .fwd_a(fwd_a), .fwd_b(fwd_b)
  );

  alu_exec u_alu (
    .fwd_a(fwd_a), .fwd_b(fwd_b),
    .reg_a(id_ex.rs1_val), .reg_b(id_ex.rs2_val),
    .mem_result(ex_mem.result), .wb_result(wb_data),
    .imm16(id_ex.imm16), .pc(id_ex.pc),
    .alu_op(id_ex.alu_op), .alu_src_imm(id_ex.alu_src_imm),
    .imm_zero_ext(id_ex.imm_zero_ext),
    .result(ex_result), .store_data(ex_store_data)
  );

  //////////////////////////////////////////////////
  // pipeline advance
  //////////////////////////////////////////////////
  // if/id holds on stall
  always_ff @(posedge clk) begin
    if (rst) begin
      if_id.valid <= 1'b0;
    end else if (!stall) begin
      if_id <= '{valid: 1'b1, pc: pc, instr: instruction};
    end
  end

  // id/ex takes a bubble on stall
  always_ff @(posedge clk) begin
    if (rst) begin
      id_ex.valid <= 1'b0;
    end else begin
      id_ex.valid        <= if_id.valid & ~stall;
      id_ex.pc           <= if_id.pc;
      // unused sources zeroed so they never match a destination
      id_ex.rs1          <= dec_uses_rs1 ? id_rs1 : '0;
      id_ex.rs2          <= dec_uses_rs2 ? id_rs2 : '0;
      id_ex.rs1_val      <= rf_rd1;
      id_ex.rs2_val      <= rf_rd2;
      id_ex.imm16        <= if_id.instr[15:0];
      id_ex.dest         <= dec_dest;
      id_ex.reg_wr       <= dec_reg_wr;
      id_ex.mem_rd       <= dec_mem_rd;
      id_ex.mem_wr       <= dec_mem_wr;
      id_ex.alu_op       <= dec_alu_op;
      id_ex.alu_src_imm  <= dec_alu_src_imm;
      id_ex.imm_zero_ext <= dec_imm_zero_ext;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      ex_mem.valid <= 1'b0;
    end else begin
      ex_mem.valid      <= id_ex.valid;
      ex_mem.dest       <= id_ex.dest;
      ex_mem.reg_wr     <= id_ex.reg_wr;
      ex_mem.mem_rd     <= id_ex.mem_rd;
      ex_mem.mem_wr     <= id_ex.mem_wr;
      ex_mem.result     <= ex_result;
      ex_mem.store_data <= ex_store_data;
    end
  end

  // read data captured at the end of the memory stage
  always_ff @(posedge clk) begin
    if (rst) begin
      mem_wb.valid <= 1'b0;
    end else begin
      mem_wb.valid     <= ex_mem.valid;
      mem_wb.dest      <= ex_mem.dest;
      mem_wb.reg_wr    <= ex_mem.reg_wr;
      mem_wb.mem_rd    <= ex_mem.mem_rd;
      mem_wb.result    <= ex_mem.result;
      mem_wb.read_data <= mem_read_data;
    end
  end

  // memory ports
  assign mem_addr       = ex_mem.result;
  assign mem_write_data = ex_mem.store_data;
  assign mem_wr         = ex_mem.valid & ex_mem.mem_wr;

  // write-back select
  assign wb_data = mem_wb.mem_rd ? mem_wb.read_data : mem_wb.result;

endmodule

//--- tb_pipeline.sv
`timescale 1ns/1ps

module tb_pipeline;
  import cpu_pkg::*;

  localparam int MAX_WAIT     = 5000;
  localparam int QUIET_CYCLES = 20;
  localparam int BODY_ITEMS   = 80;

  logic        clk = 1'b0;
  logic        rst = 1'b1;
  logic [31:0] instruction;
  logic [31:0] mem_read_data;
  logic [31:0] pc;
  logic [31:0] mem_addr;
  logic [31:0] mem_write_data;
  logic        mem_wr;

  // word memories indexed by address bits 11:2
  logic [31:0] imem [1024];
  logic [31:0] dmem [1024];
  // reference model state
  logic [31:0] mregs [32];
  logic [31:0] mdmem [1024];
  logic [31:0] exp_addr [$];
  logic [31:0] exp_data [$];

  int          seed = 6631;
  int          pos;
  int          recent [3];
  logic [31:0] end_pc;

  always #50 clk = ~clk;

  pipeline dut_i (
    .clk(clk), .rst(rst),
    .instruction(instruction), .mem_read_data(mem_read_data),
    .pc(pc), .mem_addr(mem_addr),
    .mem_write_data(mem_write_data), .mem_wr(mem_wr)
  );

  // combinational fetch and load data
  assign instruction   = imem[pc[11:2]];
  assign mem_read_data = rst ? 32'd0 : dmem[mem_addr[11:2]];

  // data memory refilled while reset is held
  // stores land on the edge
  always @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < 1024; i++) begin
        dmem[i[9:0]] <= fill_word(i);
      end
    end else if (mem_wr) begin
      dmem[mem_addr[11:2]] <= mem_write_data;
    end
  end

  //////////////////////////////////////////////////
  // reporting
  //////////////////////////////////////////////////
  task automatic abort_run(input string why);
    $display("%s", why);
    $display("*** TEST FAILED ***");
    $fatal(1);
  endtask

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      abort_run($sformatf("error: %s got %h expected %h", name, got, exp));
    end
  endtask

  //////////////////////////////////////////////////
  // random program
  //////////////////////////////////////////////////
  // word pattern that mixes every address bit
  function automatic logic [31:0] fill_word(int idx);
    logic [31:0] a;
    a = idx;
    return (a * 32'h9e37_79b1) ^ (a << 13) ^ 32'h5a5a_0ff0;
  endfunction

  function automatic int rand_below(int n);
    logic [31:0] r;
    r = $random(seed);
    return int'(r % n);
  endfunction

  // r0 now and then
  // r30 base and r31 link stay reserved
  function automatic int pick_dest();
    int d;
    d = (rand_below(12) == 0) ? 0 : 1 + rand_below(29);
    recent[2] = recent[1];
    recent[1] = recent[0];
    recent[0] = d;
    return d;
  endfunction

  // mostly one of the last three destinations for short distances
  function automatic int pick_src();
    int k;
    if (rand_below(5) < 3) begin
      k = rand_below(3);
      return recent[k[1:0]];
    end
    return rand_below(32);
  endfunction

  function automatic logic [5:0] r_fn();
    case (rand_below(9))
      0:       return FN_ADD;
      1:       return FN_SUB;
      2:       return FN_AND;
      3:       return FN_OR;
      4:       return FN_XOR;
      5:       return FN_SLL;
      6:       return FN_SRL;
      7:       return FN_SRA;
      default: return FN_SLT;
    endcase
  endfunction

  function automatic logic [5:0] i_op();
    case (rand_below(5))
      0:       return OP_ADDI;
      1:       return OP_ANDI;
      2:       return OP_ORI;
      3:       return OP_XORI;
      default: return OP_LHI;
    endcase
  endfunction

  function automatic logic [31:0] r_word(logic [5:0] fn, int rd, int rs1, int rs2);
    return {OP_RTYPE, rs1[4:0], rs2[4:0], rd[4:0], 5'd0, fn};
  endfunction

  // rt is the rs2 field that immediates and loads write
  function automatic logic [31:0] i_word(logic [5:0] op, int rs1, int rt, int imm);
    return {op, rs1[4:0], rt[4:0], imm[15:0]};
  endfunction

  function automatic logic [31:0] j_word(logic [5:0] op, int off);
    return {op, off[25:0]};
  endfunction

  task automatic emit(input logic [31:0] w);
    imem[pos[9:0]] = w;
    pos++;
  endtask

  // one non control flow op that is safe for delay slots
  task automatic add_plain_op();
    int kind;
    int d;
    int s1;
    int s2;
    kind = rand_below(9);
    if (kind < 4) begin
      s1 = pick_src();
      s2 = pick_src();
      d  = pick_dest();
      emit(r_word(r_fn(), d, s1, s2));
    end else if (kind < 7) begin
      s1 = pick_src();
      d  = pick_dest();
      emit(i_word(i_op(), s1, d, rand_below(65536)));
    end else if (kind == 7) begin
      emit(i_word(OP_SW, 30, pick_src(), 4 * rand_below(64)));
    end else begin
      d = pick_dest();
      emit(i_word(OP_LW, 30, d, 4 * rand_below(64)));
    end
  endtask

  // jal forward into a routine that returns with jr r31
  task automatic add_subroutine();
    int nsub;
    nsub = rand_below(3);
    emit(j_word(OP_JAL, 12));
    add_plain_op();
    // return point hops over the routine
    emit(j_word(OP_J, 4 * (nsub + 3)));
    add_plain_op();
    for (int k = 0; k < nsub; k++) begin
      add_plain_op();
    end
    emit(i_word(OP_JR, 31, 0, 0));
    add_plain_op();
  endtask

  task automatic build_program();
    int d;
    int src;
    int skip;
    pos       = 0;
    recent[0] = 1;
    recent[1] = 2;
    recent[2] = 3;
    for (int i = 0; i < 1024; i++) begin
      imem[i[9:0]] = 32'd0;
    end
    // register seeding with the upper half first
    for (int r = 1; r < 30; r++) begin
      emit(i_word(OP_LHI, 0, r, rand_below(65536)));
      emit(i_word(OP_ORI, r, r, rand_below(65536)));
    end
    emit(i_word(OP_ORI, 0, 30, 'h400));
    emit(i_word(OP_LHI, 0, 31, rand_below(65536)));
    // writes that must vanish
    emit(i_word(OP_LHI, 0, 0, 'h1234));
    emit(r_word(FN_ADD, 0, 1, 2));
    for (int n = 0; n < BODY_ITEMS; n++) begin
      if (n == BODY_ITEMS / 2) begin
        add_subroutine();
      end
      case (rand_below(10))
        6: begin
          // load with the very next op using it
          d = pick_dest();
          emit(i_word(OP_LW, 30, d, 4 * rand_below(64)));
          emit(i_word(OP_ADDI, d, pick_dest(), rand_below(65536)));
        end
        7: begin
          src  = (rand_below(3) == 0) ? 0 : pick_src();
          skip = rand_below(3);
          emit(i_word((rand_below(2) == 0) ? OP_BEQZ : OP_BNEZ, src, 0, 4 * (skip + 1)));
          add_plain_op();
          for (int k = 0; k < skip; k++) begin
            add_plain_op();
          end
        end
        8: begin
          skip = rand_below(3);
          emit(j_word(OP_J, 4 * (skip + 1)));
          add_plain_op();
          for (int k = 0; k < skip; k++) begin
            add_plain_op();
          end
        end
        default: add_plain_op();
      endcase
    end
    // dump every register including r0
    for (int r = 0; r < 32; r++) begin
      emit(i_word(OP_SW, 0, r, 'h800 + 4 * r));
    end
    end_pc = pos * 4;
    emit(j_word(OP_J, -4));
    emit(32'd0);
  endtask

  //////////////////////////////////////////////////
  // instruction set model
  //////////////////////////////////////////////////
  task automatic set_reg(input logic [4:0] idx, input logic [31:0] val);
    if (idx != 5'd0) begin
      mregs[idx] = val;
    end
  endtask

  // cur runs one instruction behind nxt to give the delay slot
  task automatic run_model();
    logic [31:0] cur;
    logic [31:0] nxt;
    logic [31:0] tgt;
    logic [31:0] ins;
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] imm_s;
    logic [31:0] imm_z;
    logic [31:0] addr;
    logic [5:0]  op;
    logic [4:0]  s1;
    logic [4:0]  s2;
    logic [4:0]  d;
    logic        redirect;
    int          steps;
    for (int r = 0; r < 32; r++) begin
      mregs[r[4:0]] = 32'd0;
    end
    for (int i = 0; i < 1024; i++) begin
      mdmem[i[9:0]] = fill_word(i);
    end
    cur   = 32'd0;
    nxt   = 32'd4;
    steps = 0;
    while (cur != end_pc) begin
      if (steps > 20000) begin
        abort_run("reference model never reached the end of the program");
      end
      ins      = imem[cur[11:2]];
      op       = ins[31:26];
      s1       = ins[25:21];
      s2       = ins[20:16];
      d        = ins[15:11];
      a        = mregs[s1];
      b        = mregs[s2];
      imm_s    = {{16{ins[15]}}, ins[15:0]};
      imm_z    = {16'd0, ins[15:0]};
      addr     = a + imm_s;
      redirect = 1'b0;
      tgt      = 32'd0;
      case (op)
        OP_RTYPE: begin
          case (ins[5:0])
            FN_ADD:  set_reg(d, a + b);
            FN_SUB:  set_reg(d, a - b);
            FN_AND:  set_reg(d, a & b);
            FN_OR:   set_reg(d, a | b);
            FN_XOR:  set_reg(d, a ^ b);
            FN_SLL:  set_reg(d, a << b[4:0]);
            FN_SRL:  set_reg(d, a >> b[4:0]);
            FN_SRA:  set_reg(d, $signed(a) >>> b[4:0]);
            FN_SLT:  set_reg(d, ($signed(a) < $signed(b)) ? 32'd1 : 32'd0);
            default: ;
          endcase
        end
        OP_ADDI: set_reg(s2, a + imm_s);
        OP_ANDI: set_reg(s2, a & imm_z);
        OP_ORI:  set_reg(s2, a | imm_z);
        OP_XORI: set_reg(s2, a ^ imm_z);
        OP_LHI:  set_reg(s2, {ins[15:0], 16'd0});
        OP_LW:   set_reg(s2, mdmem[addr[11:2]]);
        OP_SW: begin
          mdmem[addr[11:2]] = b;
          exp_addr.push_back(addr);
          exp_data.push_back(b);
        end
        OP_BEQZ: begin
          redirect = (a == 32'd0);
          tgt      = cur + 32'd4 + imm_s;
        end
        OP_BNEZ: begin
          redirect = (a != 32'd0);
          tgt      = cur + 32'd4 + imm_s;
        end
        OP_J, OP_JAL: begin
          redirect = 1'b1;
          tgt      = cur + 32'd4 + {{6{ins[25]}}, ins[25:0]};
          // link skips the delay slot
          if (op == OP_JAL) begin
            set_reg(5'd31, cur + 32'd8);
          end
        end
        OP_JR: begin
          redirect = 1'b1;
          tgt      = a;
        end
        default: ;
      endcase
      cur = nxt;
      nxt = redirect ? tgt : nxt + 32'd4;
      steps++;
    end
  endtask

  //////////////////////////////////////////////////
  // run
  //////////////////////////////////////////////////
  task automatic apply_reset();
    for (int i = 0; i < 4; i++) begin
      @(posedge clk);
      #5;
      check_value("mem_wr", {31'd0, mem_wr}, 32'd0);
      check_value("pc", pc, 32'd0);
    end
    rst = 1'b0;
  endtask

  initial begin
    int total;
    int seen;
    int cycles;
    build_program();
    run_model();
    total = exp_addr.size();
    seen  = 0;
    $display("program of %0d words, %0d stores expected", pos, total);
    apply_reset();

    // every store checked in order against the model
    cycles = 0;
    while (seen < total) begin
      @(negedge clk);
      cycles++;
      if (cycles > MAX_WAIT) begin
        abort_run($sformatf("timeout with %0d of %0d stores seen", seen, total));
      end
      if (mem_wr) begin
        check_value("mem_addr", mem_addr, exp_addr.pop_front());
        check_value("mem_write_data", mem_write_data, exp_data.pop_front());
        seen++;
      end
    end

    // self loop from here on so nothing more may be stored
    for (int k = 0; k < QUIET_CYCLES; k++) begin
      @(negedge clk);
      if (mem_wr) begin
        abort_run("store seen after the last expected store");
      end
    end

    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

//--- sources.f
cpu_pkg.sv
reg_file.sv
fetch_unit.sv
decode_ctrl.sv
hazard_unit.sv
alu_exec.sv
pipeline.sv
tb_pipeline.sv

//--- run_sim.sh
#!/usr/bin/env bash
# build with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_pipeline -f sources.f -o tb_pipeline_sim \
  && ./obj_dir/tb_pipeline_sim > sim.log 2>&1 \
  || echo "build or simulation stopped with an error"
cat sim.log 2>/dev/null
grep -qF '*** TEST PASSED ***' sim.log 2>/dev/null && echo "PASS" || { echo "FAIL"; exit 1; }
